/* logic/aluOpPkg.sv */
package aluOpPkg;

  // bit 5 marks the 32-bit word form, low 5 bits pick the operation
  localparam int wordBit = 5;

  // jump and branch ops occupy this range of the low 5 bits
  localparam logic [4:0] ctlFirst = 5'd21;
  localparam logic [4:0] ctlLast  = 5'd28;

  typedef enum logic [5:0] {
    opSll    = 6'd1,
    opSrl    = 6'd2,
    opSra    = 6'd3,
    opAdd    = 6'd4,  // also loads and stores
    opSub    = 6'd5,
    opMul    = 6'd10,
    opMulh   = 6'd11,
    opMulhu  = 6'd12,
    opMulhsu = 6'd13,
    opXor    = 6'd14,
    opOr     = 6'd15,
    opAnd    = 6'd16,
    opSlt    = 6'd17,
    opSltu   = 6'd18,
    opAuipc  = 6'd19,
    opLui    = 6'd20,
    opJalr   = 6'd21,
    opJal    = 6'd22,
    opBeq    = 6'd23,
    opBne    = 6'd24,
    opBlt    = 6'd25,
    opBge    = 6'd26,
    opBltu   = 6'd27,
    opBgeu   = 6'd28,
    opSllw   = 6'd33,
    opSrlw   = 6'd34,
    opSraw   = 6'd35,
    opAddw   = 6'd36,
    opSubw   = 6'd37,
    opMulw   = 6'd42
  } aluOpT;

  // operand source, bit 2 picks lane 2
  typedef enum logic [2:0] {
    fwdReg = 3'b000,  // register file value
    fwdW1  = 3'b001,
    fwdM1  = 3'b010,
    fwdW2  = 3'b101,
    fwdM2  = 3'b110
  } fwdSelT;

endpackage

/* logic/execPkg.sv */
package execPkg;

  localparam int xlen = 64;

  typedef logic [xlen-1:0] xwordT;

  // decoded control for one lane
  typedef struct packed {
    aluOpPkg::aluOpT   aluOp;
    logic              aluSrc;  // operand B from immediate
    logic              jump;
    logic              branch;
    aluOpPkg::fwdSelT  fwdA;
    aluOpPkg::fwdSelT  fwdB;
  } laneCtrlT;

  // register file reads, pc and extended immediate
  typedef struct packed {
    xwordT rd1;
    xwordT rd2;
    xwordT pc;
    xwordT imm;
  } laneDataT;

  // combinational lane result, registered by the commit block
  typedef struct packed {
    xwordT aluResult;
    xwordT writeData;  // forwarded B, store data
    logic  redirect;
    xwordT target;
  } laneOutT;

  // values a lane can forward from
  typedef struct packed {
    xwordT resultW1;
    xwordT resultW2;
    xwordT aluResultM1;
    xwordT aluResultM2;
  } fwdBusT;

endpackage

/* logic/laneAlu.sv */
`timescale 1ns/1ps

module laneAlu (
  input  execPkg::laneCtrlT ctrl,
  input  execPkg::laneDataT data,
  input  execPkg::fwdBusT   fwd,
  output execPkg::laneOutT  out
);
  import aluOpPkg::*;
  import execPkg::*;

  xwordT             fwdA;
  xwordT             writeData;
  xwordT             srcA;
  xwordT             srcB;
  xwordT             result;
  xwordT             target;
  logic [31:0]       wordRes;
  logic [2*xlen-1:0] product;
  logic              signA;
  logic              signB;
  logic              isCtl;
  logic              cond;

  function automatic xwordT pickSrc(fwdSelT sel, xwordT regVal, fwdBusT bus);
    case (sel)
      fwdReg:  pickSrc = regVal;
      fwdW1:   pickSrc = bus.resultW1;
      fwdW2:   pickSrc = bus.resultW2;
      fwdM1:   pickSrc = bus.aluResultM1;
      fwdM2:   pickSrc = bus.aluResultM2;
      default: pickSrc = '0;  // undefined code
    endcase
  endfunction

  assign fwdA      = pickSrc(ctrl.fwdA, data.rd1, fwd);
  assign writeData = pickSrc(ctrl.fwdB, data.rd2, fwd);

  assign srcA = (ctrl.aluOp == opAuipc) ? data.pc : fwdA;
  assign srcB = ctrl.aluSrc ? data.imm : writeData;

  // one shared 128-bit multiplier, operands extended per op
  assign signA   = (ctrl.aluOp == opMulh) || (ctrl.aluOp == opMulhsu);
  assign signB   = (ctrl.aluOp == opMulh);
  assign product = {{xlen{signA & srcA[xlen-1]}}, srcA} *
                   {{xlen{signB & srcB[xlen-1]}}, srcB};

  always_comb begin
    result  = '0;
    wordRes = '0;
    case (ctrl.aluOp)
      opSll:    result = srcA << srcB[5:0];
      opSrl:    result = srcA >> srcB[5:0];
      opSra:    result = $signed(srcA) >>> srcB[5:0];
      opAdd:    result = srcA + srcB;
      opSub:    result = srcA - srcB;
      opMul:    result = product[xlen-1:0];
      opMulh:   result = product[2*xlen-1:xlen];
      opMulhu:  result = product[2*xlen-1:xlen];
      opMulhsu: result = product[2*xlen-1:xlen];
      opXor:    result = srcA ^ srcB;
      opOr:     result = srcA | srcB;
      opAnd:    result = srcA & srcB;
      opSlt:    result = {{(xlen-1){1'b0}}, $signed(srcA) < $signed(srcB)};
      opSltu:   result = {{(xlen-1){1'b0}}, srcA < srcB};
      opAuipc:  result = srcA + srcB;  // srcA already holds pc
      opLui:    result = srcB;
      opSllw:   wordRes = srcA[31:0] << srcB[4:0];
      opSrlw:   wordRes = srcA[31:0] >> srcB[4:0];
      opSraw:   wordRes = $signed(srcA[31:0]) >>> srcB[4:0];
      opAddw:   wordRes = srcA[31:0] + srcB[31:0];
      opSubw:   wordRes = srcA[31:0] - srcB[31:0];
      opMulw:   wordRes = product[31:0];
      default:  result = '0;  // jumps, branches, dropped and illegal ops
    endcase
    if (ctrl.aluOp[wordBit]) begin
      result = {{32{wordRes[31]}}, wordRes};  // sign extend word result
    end
  end

  // branch compare on the same operands as the ALU
  always_comb begin
    case (ctrl.aluOp)
      opBeq:   cond = (srcA == srcB);
      opBne:   cond = (srcA != srcB);
      opBlt:   cond = ($signed(srcA) < $signed(srcB));
      opBge:   cond = ($signed(srcA) >= $signed(srcB));
      opBltu:  cond = (srcA < srcB);
      opBgeu:  cond = (srcA >= srcB);
      default: cond = 1'b0;
    endcase
  end

  assign isCtl = !ctrl.aluOp[wordBit] &&
                 (ctrl.aluOp[4:0] >= ctlFirst) && (ctrl.aluOp[4:0] <= ctlLast);

  always_comb begin
    if (!isCtl) begin
      target = '0;
    end else if (ctrl.aluOp == opJalr) begin
      target = srcA + data.imm;  // register relative
    end else begin
      target = data.pc + data.imm;
    end
  end

  assign out = '{
    aluResult: result,
    writeData: writeData,
    redirect:  ctrl.jump | (ctrl.branch & cond),
    target:    target
  };

endmodule

/* logic/executeCommit.sv */
`timescale 1ns/1ps

module executeCommit (
  input  logic             clk,
  input  logic             rstN,
  input  logic             enableE,
  input  execPkg::laneOutT lane1,
  input  execPkg::laneOutT lane2,
  output execPkg::xwordT   aluResultM1,
  output execPkg::xwordT   aluResultM2,
  output execPkg::xwordT   writeDataM1,
  output execPkg::xwordT   writeDataM2,
  output logic             pcSrc,
  output execPkg::xwordT   pcTarget,
  output logic             lane2Kill
);

  // lane 1 holds the older instruction, so its redirect wins
  always_ff @(posedge clk) begin
    if (!rstN) begin
      aluResultM1 <= '0;
      aluResultM2 <= '0;
      writeDataM1 <= '0;
      writeDataM2 <= '0;
      pcSrc       <= 1'b0;
      pcTarget    <= '0;
      lane2Kill   <= 1'b0;
    end else if (enableE) begin  // low enableE holds everything
      aluResultM1 <= lane1.aluResult;
      aluResultM2 <= lane2.aluResult;
      writeDataM1 <= lane1.writeData;
      writeDataM2 <= lane2.writeData;
      if (lane1.redirect) begin
        pcSrc     <= 1'b1;
        pcTarget  <= lane1.target;
        lane2Kill <= 1'b1;  // younger lane is squashed
      end else begin
        pcSrc     <= lane2.redirect;
        pcTarget  <= lane2.target;
        lane2Kill <= 1'b0;
      end
    end
  end

endmodule

/* logic/dualExecute.sv */
`timescale 1ns/1ps

module dualExecute (
  input  logic             clk,
  input  logic             rstN,
  input  logic             enableE,
  input  execPkg::laneCtrlT ctrl1,
  input  execPkg::laneCtrlT ctrl2,
  input  execPkg::laneDataT data1,
  input  execPkg::laneDataT data2,
  input  execPkg::xwordT   resultW1,
  input  execPkg::xwordT   resultW2,
  output execPkg::xwordT   aluResultM1,
  output execPkg::xwordT   aluResultM2,
  output execPkg::xwordT   writeDataM1,
  output execPkg::xwordT   writeDataM2,
  output logic             pcSrc,
  output execPkg::xwordT   pcTarget,
  output logic             lane2Kill
);
  import aluOpPkg::*;
  import execPkg::*;

  fwdBusT  fwd;
  laneOutT out1;
  laneOutT out2;

  // M values come straight back from the commit registers
  assign fwd = '{
    resultW1:    resultW1,
    resultW2:    resultW2,
    aluResultM1: aluResultM1,
    aluResultM2: aluResultM2
  };

  laneAlu lane1 (.ctrl(ctrl1), .data(data1), .fwd(fwd), .out(out1));

  laneAlu lane2 (.ctrl(ctrl2), .data(data2), .fwd(fwd), .out(out2));

  executeCommit commit (
    .clk        (clk),
    .rstN       (rstN),
    .enableE    (enableE),
    .lane1      (out1),
    .lane2      (out2),
    .aluResultM1(aluResultM1),
    .aluResultM2(aluResultM2),
    .writeDataM1(writeDataM1),
    .writeDataM2(writeDataM2),
    .pcSrc      (pcSrc),
    .pcTarget   (pcTarget),
    .lane2Kill  (lane2Kill)
  );

  // hazard unit only issues defined codes while the stage advances
  property legalFwd(logic [2:0] sel);
    @(posedge clk) disable iff (!rstN)
      enableE |-> sel inside {fwdReg, fwdW1, fwdW2, fwdM1, fwdM2};
  endproperty

  lane1FwdA: assert property (legalFwd(ctrl1.fwdA)) else $error("bad fwdA on lane 1");
  lane1FwdB: assert property (legalFwd(ctrl1.fwdB)) else $error("bad fwdB on lane 1");
  lane2FwdA: assert property (legalFwd(ctrl2.fwdA)) else $error("bad fwdA on lane 2");
  lane2FwdB: assert property (legalFwd(ctrl2.fwdB)) else $error("bad fwdB on lane 2");

endmodule

/* testbench/execModel.svh */
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// model copy of the execute/memory registers
xwordT expAluM1;
xwordT expAluM2;
xwordT expDataM1;
xwordT expDataM2;
logic  expPcSrc;
xwordT expTarget;
logic  expKill;

function automatic xwordT sext32(logic [31:0] w);
  return {{32{w[31]}}, w};
endfunction

// W values come from the driven inputs, M values from the model registers
function automatic xwordT sourceValue(logic [2:0] code, xwordT regVal);
  case (code)
    3'd0:    return regVal;
    3'd1:    return resultW1;
    3'd5:    return resultW2;
    3'd2:    return expAluM1;
    3'd6:    return expAluM2;
    default: return '0;
  endcase
endfunction

function automatic xwordT expectResult(logic [5:0] op, xwordT a, xwordT b);
  logic [127:0] pu;
  xwordT        hu;
  pu = {64'd0, a} * {64'd0, b};
  hu = pu[127:64];
  case (op)
    6'd1:    return a << b[5:0];
    6'd2:    return a >> b[5:0];
    6'd3:    return $signed(a) >>> b[5:0];
    6'd4:    return a + b;
    6'd5:    return a - b;
    6'd10:   return pu[63:0];
    6'd11:   return hu - (a[63] ? b : 64'd0) - (b[63] ? a : 64'd0);  // signed correction
    6'd12:   return hu;
    6'd13:   return hu - (a[63] ? b : 64'd0);
    6'd14:   return a ^ b;
    6'd15:   return a | b;
    6'd16:   return a & b;
    6'd17:   return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
    6'd18:   return (a < b) ? 64'd1 : 64'd0;
    6'd19:   return a + b;  // a is pc here
    6'd20:   return b;
    6'd33:   return sext32(a[31:0] << b[4:0]);
    6'd34:   return sext32(a[31:0] >> b[4:0]);
    6'd35:   return sext32($signed(a[31:0]) >>> b[4:0]);
    6'd36:   return sext32(a[31:0] + b[31:0]);
    6'd37:   return sext32(a[31:0] - b[31:0]);
    6'd42:   return sext32(pu[31:0]);
    default: return '0;  // jumps, branches, div/rem and unknown codes
  endcase
endfunction

function automatic logic branchTaken(logic [5:0] op, xwordT a, xwordT b);
  case (op)
    6'd23:   return a == b;
    6'd24:   return a != b;
    6'd25:   return $signed(a) < $signed(b);
    6'd26:   return !($signed(a) < $signed(b));
    6'd27:   return a < b;
    6'd28:   return !(a < b);
    default: return 1'b0;
  endcase
endfunction

function automatic laneOutT predictLane(laneCtrlT c, laneDataT d);
  laneOutT    p;
  logic [5:0] op;
  xwordT      a;
  xwordT      b;
  op = c.aluOp;
  a  = sourceValue(c.fwdA, d.rd1);
  b  = sourceValue(c.fwdB, d.rd2);
  p.writeData = b;
  if (op == 6'd19) a = d.pc;  // auipc
  if (c.aluSrc) b = d.imm;
  p.aluResult = expectResult(op, a, b);
  p.redirect  = c.jump | (c.branch & branchTaken(op, a, b));
  if (op >= 6'd21 && op <= 6'd28) begin
    p.target = (op == 6'd21) ? a + d.imm : d.pc + d.imm;
  end else begin
    p.target = '0;
  end
  return p;
endfunction

// called at the rising edge with the inputs the DUT samples there
task automatic stepModel();
  laneOutT p1;
  laneOutT p2;
  if (!rstN) begin
    expAluM1  = '0;
    expAluM2  = '0;
    expDataM1 = '0;
    expDataM2 = '0;
    expPcSrc  = 1'b0;
    expTarget = '0;
    expKill   = 1'b0;
  end else if (enableE) begin
    p1 = predictLane(ctrl1, data1);
    p2 = predictLane(ctrl2, data2);
    expAluM1  = p1.aluResult;
    expAluM2  = p2.aluResult;
    expDataM1 = p1.writeData;
    expDataM2 = p2.writeData;
    expPcSrc  = p1.redirect | p2.redirect;
    expTarget = p1.redirect ? p1.target : p2.target;  // older lane first
    expKill   = p1.redirect;
  end
endtask

`endif

/* testbench/dualExecuteTb.sv */
`timescale 1ns/1ps

module dualExecuteTb;
  import aluOpPkg::*;
  import execPkg::*;

  localparam int resetCycles  = 4;
  localparam int randomCycles = 2000;
  localparam int cycleLimit   = resetCycles + randomCycles + 96;  // small slack

  logic     clk;
  logic     rstN;
  logic     enableE;
  laneCtrlT ctrl1;
  laneCtrlT ctrl2;
  laneDataT data1;
  laneDataT data2;
  xwordT    resultW1;
  xwordT    resultW2;
  xwordT    aluResultM1;
  xwordT    aluResultM2;
  xwordT    writeDataM1;
  xwordT    writeDataM2;
  logic     pcSrc;
  xwordT    pcTarget;
  logic     lane2Kill;

  integer seed;
  int     errorCount;
  int     checkCount;
  int     cycleCount;

  // kept opcodes, then a few illegal and dropped ones
  logic [5:0] opPool [0:35] = '{
    6'd1, 6'd2, 6'd3, 6'd4, 6'd5, 6'd10, 6'd11, 6'd12, 6'd13, 6'd14,
    6'd15, 6'd16, 6'd17, 6'd18, 6'd19, 6'd20, 6'd21, 6'd22, 6'd23, 6'd24,
    6'd25, 6'd26, 6'd27, 6'd28, 6'd33, 6'd34, 6'd35, 6'd36, 6'd37, 6'd42,
    6'd0, 6'd6, 6'd8, 6'd29, 6'd38, 6'd63
  };
  logic [2:0] fwdPool [0:4] = '{3'd0, 3'd1, 3'd2, 3'd5, 3'd6};

  `include "execModel.svh"

  dualExecute u_dut (
    .clk        (clk),
    .rstN       (rstN),
    .enableE    (enableE),
    .ctrl1      (ctrl1),
    .ctrl2      (ctrl2),
    .data1      (data1),
    .data2      (data2),
    .resultW1   (resultW1),
    .resultW2   (resultW2),
    .aluResultM1(aluResultM1),
    .aluResultM2(aluResultM2),
    .writeDataM1(writeDataM1),
    .writeDataM2(writeDataM2),
    .pcSrc      (pcSrc),
    .pcTarget   (pcTarget),
    .lane2Kill  (lane2Kill)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int randBelow(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // mix of full width, 32-bit and tiny values so branches see equal operands
  function automatic xwordT randOperand();
    xwordT v;
    v = {$random(seed), $random(seed)};
    case (randBelow(4))
      0:       v = {{61{v[2]}}, v[2:0]};
      1:       v = {{32{v[31]}}, v[31:0]};
      default: v = v;
    endcase
    return v;
  endfunction

  function automatic laneCtrlT randomCtrl();
    laneCtrlT   c;
    logic [5:0] op;
    op       = opPool[6'(randBelow(36))];
    c.aluOp  = aluOpT'(op);
    c.branch = (op >= 6'd23 && op <= 6'd28);
    c.jump   = (op == 6'd21 || op == 6'd22);
    c.aluSrc = c.branch ? 1'b0 : 1'($random(seed));  // branches compare registers
    c.fwdA   = fwdSelT'(fwdPool[3'(randBelow(5))]);
    c.fwdB   = fwdSelT'(fwdPool[3'(randBelow(5))]);
    return c;
  endfunction

  function automatic laneDataT randomData();
    laneDataT d;
    d.rd1 = randOperand();
    d.rd2 = randOperand();
    d.pc  = randOperand();
    d.imm = randOperand();
    return d;
  endfunction

  task automatic driveRandom();
    enableE  <= (randBelow(8) != 0);  // stall about one cycle in eight
    ctrl1    <= randomCtrl();
    ctrl2    <= randomCtrl();
    data1    <= randomData();
    data2    <= randomData();
    resultW1 <= randOperand();
    resultW2 <= randOperand();
  endtask

  function automatic void compareWord(string name, xwordT got, xwordT want);
    if (got !== want) begin
      errorCount++;
      $display("Fail at %0t: %s is %h, expected %h", $time, name, got, want);
    end
  endfunction

  task automatic checkOutputs();
    checkCount++;
    compareWord("aluResultM1", aluResultM1, expAluM1);
    compareWord("aluResultM2", aluResultM2, expAluM2);
    compareWord("writeDataM1", writeDataM1, expDataM1);
    compareWord("writeDataM2", writeDataM2, expDataM2);
    compareWord("pcSrc", 64'(pcSrc), 64'(expPcSrc));
    compareWord("pcTarget", pcTarget, expTarget);
    compareWord("lane2Kill", 64'(lane2Kill), 64'(expKill));
  endtask

  initial begin
    seed       = 85;
    errorCount = 0;
    checkCount = 0;
    rstN       = 1'b0;
    enableE    = 1'b0;
    ctrl1      = '0;
    ctrl2      = '0;
    data1      = '0;
    data2      = '0;
    resultW1   = '0;
    resultW2   = '0;
    // reset, then release; last check here is the first cycle out of reset
    for (int i = 0; i < resetCycles; i++) begin
      @(posedge clk);
      stepModel();
      driveRandom();
      if (i == resetCycles - 1) begin
        rstN <= 1'b1;
      end
      @(negedge clk);
      checkOutputs();
    end
    for (int i = 0; i < randomCycles; i++) begin
      @(posedge clk);
      stepModel();
      driveRandom();
      @(negedge clk);  // registered outputs settled
      checkOutputs();
    end
    $display("Checked %0d cycles, %0d errors", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    cycleCount = 0;
    forever begin
      @(posedge clk);
      cycleCount++;
      if (cycleCount >= cycleLimit) begin
        $display("Timeout: run did not complete within %0d cycles", cycleLimit);
        $display("Regression failed");
        $finish;
      end
    end
  end

endmodule

/* src.f */
+incdir+testbench
logic/aluOpPkg.sv
logic/execPkg.sv
logic/laneAlu.sv
logic/executeCommit.sv
logic/dualExecute.sv
testbench/dualExecuteTb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module dualExecuteTb \
    -Mdir obj_dir -f src.f &&
  ./obj_dir/VdualExecuteTb | tee /dev/stderr | grep -x "Regression passed" > /dev/null ||
  { echo "run.sh: simulation did not pass" >&2; exit 1; }
